//--- Bender.yml
package:
  name: cpu8

sources:
  - verilog/cpu_pkg.sv
  - verilog/alu.sv
  - verilog/control_unit.sv
  - verilog/reg_file.sv
  - verilog/pointer_unit.sv
  - verilog/cpu_top.sv
  - target: simulation
    files:
      - sim/tb_cpu.sv

//--- files.f
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/control_unit.sv
verilog/reg_file.sv
verilog/pointer_unit.sv
verilog/cpu_top.sv
sim/tb_cpu.sv

//--- sim/cpu_patterns.txt
# M addr b0..b7 : program bytes, S addr data : expected stores in order
# R pct : chance in percent of a wait state on each cycle
R 30
M 0000 C2 00 C3 01 C0 5A C1 A5
M 0008 A0 A1 01 A0 0D A1 11 A0
M 0010 1D A1 21 38 A0 4D A1 60
M 0018 A0 75 A1 78 A0 41 A0 C2
M 0020 27 C3 00 E0 C0 EE A0 C2
M 0028 00 C3 01 C0 11 A0 E1 C0
M 0030 22 A0 C2 3A C3 00 E6 C0
M 0038 EE A0 C2 00 C3 01 C0 33
M 0040 A0 E3 C0 44 A0 C2 57 C3
M 0048 00 E8 C0 55 C2 00 C3 01
M 0050 A0 A1 EC C0 66 A0 00 C1
M 0058 77 E8 00 00 00 00 00 00
S 0100 5A
S 0100 A5
S 0100 FF
S 0100 A4
S 0100 5B
S 0100 49
S 0100 B6
S 0100 92
S 0100 5B
S 0100 91
S 0100 00
S 0100 91
S 0100 11
S 0100 22
S 0100 33
S 0100 44
S 0100 55
S 0100 77
S 0100 66

//--- sim/tb_cpu.sv
module tb_cpu;
    import cpu_pkg::*;

    localparam int TIMEOUT = 400;   // cycles allowed per store

    logic        clk_i;
    logic        rst_n_i;
    logic [7:0]  mem_rdata;
    logic        mem_rdy;
    mem_req_t    mem_req;

    logic [7:0]  image [65536];   // program as loaded from file
    logic [7:0]  mem [65536];     // live memory seen by the DUT
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    int          stall_pct;
    int          stall_on;
    int          n_st;            // stores seen in this run
    logic        prev_rdy;
    mem_req_t    prev_req;

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    cpu_top dut0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mem_rdata_i (mem_rdata),
        .mem_rdy_i   (mem_rdy),
        .mem_req_o   (mem_req)
    );

    assign mem_rdata = mem[mem_req.addr];   // reads answer at once

    task automatic check_eq(input string name, input logic [39:0] got, input logic [39:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    // ==============================
    // pattern file
    // ==============================
    task automatic load_patterns();
        int             fd;
        int             code;
        logic [7:0]     tag;
        logic [1023:0]  line;
        logic [15:0]    addr;
        logic [7:0]     b [8];
        fd = $fopen("sim/cpu_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open sim/cpu_patterns.txt");
        end
        foreach (image[i]) begin
            image[i] = 8'h00;
        end
        stall_pct = 0;
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                code = $fgets(line, fd);    // rest of comment
            end else if (tag == "M") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", addr,
                               b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]);
                for (int k = 0; k < 8; k++) begin
                    image[addr + k] = b[k];
                end
            end else if (tag == "S") begin
                code = $fscanf(fd, "%h %h", addr, b[0]);
                exp_addr.push_back(addr);
                exp_data.push_back(b[0]);
            end else if (tag == "R") begin
                code = $fscanf(fd, "%d", stall_pct);
            end else begin
                abort_run("unknown line type in pattern file");
            end
        end
        $fclose(fd);
    endtask

    // ready level changed just after the edge
    initial begin
        void'($urandom(62521));
        forever begin
            @(posedge clk_i);
            #2;
            mem_rdy = stall_on ? ($urandom_range(99) >= stall_pct) : 1'b1;
        end
    end

    // ==============================
    // bus monitor and memory writes
    // ==============================
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            check_eq("mem_req_o.we", mem_req.we, 0);   // no write in reset
            prev_rdy = 1'b1;
        end else begin
            if (!prev_rdy) begin
                check_eq("mem_req_o", mem_req, prev_req);   // held through stall
            end
            if (mem_rdy && mem_req.we) begin
                if (n_st < exp_addr.size()) begin
                    check_eq("mem_req_o.addr", mem_req.addr, exp_addr[n_st]);
                    check_eq("mem_req_o.wdata", mem_req.wdata, exp_data[n_st]);
                end
                mem[mem_req.addr] = mem_req.wdata;
                n_st++;
            end
            prev_rdy = mem_rdy;
        end
        prev_req = mem_req;
    end

    task automatic run_program(input int stalls);
        int cyc;
        #2;
        rst_n_i  = 1'b0;
        stall_on = stalls;
        foreach (mem[i]) begin
            mem[i] = image[i];
        end
        n_st = 0;
        repeat (3) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        // first request after reset
        @(negedge clk_i);
        check_eq("mem_req_o.addr", mem_req.addr, 16'h0000);
        check_eq("mem_req_o.rd", mem_req.rd, 1);
        check_eq("mem_req_o.we", mem_req.we, 0);
        for (int k = 0; k < exp_addr.size(); k++) begin
            cyc = 0;
            while (n_st <= k) begin
                @(posedge clk_i);
                cyc++;
                if (cyc > TIMEOUT) begin
                    abort_run($sformatf("timeout waiting for store %0d (stalls %0d)",
                                        k, stalls));
                end
            end
        end
    endtask

    initial begin
        rst_n_i  = 1'b0;
        mem_rdy  = 1'b1;
        stall_on = 0;
        n_st     = 0;
        prev_rdy = 1'b1;
        load_patterns();
        run_program(0);
        run_program(1);   // same program with random wait states
        $display("Everything OK");
        $finish;
    end

endmodule

//--- verilog/alu.sv
module alu (
    input  logic [3:0]      op_i,
    input  logic [7:0]      a_i,
    input  logic [7:0]      b_i,
    input  logic            carry_i,
    output logic [7:0]      res_o,
    output cpu_pkg::flags_t flags_o
);
    import cpu_pkg::*;

    logic [7:0] arg;    // second operand or 1 for inc/dec
    logic [8:0] wide;   // sum with carry or borrow on top
    logic       arith;  // add/sub family
    logic       is_sub;
    logic       c_out;
    logic       v_out;

    assign arg = (op_i == ALU_INC || op_i == ALU_DEC) ? 8'h01 : b_i;

    always_comb begin
        wide   = '0;
        arith  = 1'b0;
        is_sub = 1'b0;
        res_o  = '0;
        c_out  = carry_i;   // logic ops pass carry through
        unique case (op_i)
            ALU_ADD, ALU_INC: begin
                arith = 1'b1;
                wide  = {1'b0, a_i} + {1'b0, arg};
            end
            ALU_ADC: begin
                arith = 1'b1;
                wide  = {1'b0, a_i} + {1'b0, arg} + {8'h00, carry_i};
            end
            ALU_SUB, ALU_DEC: begin
                arith  = 1'b1;
                is_sub = 1'b1;
                wide   = {1'b0, a_i} - {1'b0, arg};  // bit 8 is borrow
            end
            ALU_SBC: begin
                arith  = 1'b1;
                is_sub = 1'b1;
                wide   = {1'b0, a_i} - {1'b0, arg} - {8'h00, carry_i};
            end
            ALU_AND: res_o = a_i & b_i;
            ALU_OR:  res_o = a_i | b_i;
            ALU_XOR: res_o = a_i ^ b_i;
            ALU_NOT: res_o = ~a_i;
            ALU_MOV: res_o = b_i;
            ALU_SHL: begin
                res_o = {a_i[6:0], 1'b0};
                c_out = a_i[7];
            end
            ALU_SHR: begin
                res_o = {1'b0, a_i[7:1]};
                c_out = a_i[0];
            end
            ALU_ROL: begin
                res_o = {a_i[6:0], a_i[7]};
                c_out = a_i[7];
            end
            ALU_ROR: begin
                res_o = {a_i[0], a_i[7:1]};
                c_out = a_i[0];
            end
            ALU_CLR: c_out = 1'b0;
        endcase
        if (arith) begin
            res_o = wide[7:0];
            c_out = wide[8];
        end
    end

    // signed overflow when the sign of a flips against the operand sign rule
    assign v_out = arith & (a_i[7] ^ res_o[7])
                 & (is_sub ? (a_i[7] ^ arg[7]) : ~(a_i[7] ^ arg[7]));

    assign flags_o = '{v: v_out, n: res_o[7], c: c_out, z: (res_o == 8'h00)};

endmodule

//--- verilog/control_unit.sv
module control_unit (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            mem_rdy_i,   // level that holds everything when low
    input  logic [7:0]      mem_rdata_i,
    input  cpu_pkg::flags_t flags_i,
    output cpu_pkg::ctrl_t  ctrl_o
);
    import cpu_pkg::*;

    instr_u ir;          // current instruction
    logic   cycle;       // 0 fetch, 1 execute
    logic   supercycle;  // second pass of LDI

    // decoded instruction
    logic       is_alu;
    logic       op_ld;
    logic       op_st;
    logic       op_ldi;
    logic       op_jmp;
    logic [3:0] flag_vec;
    logic       flag_sel;
    logic       taken;   // jump condition met
    logic       do_swap;

    // ==============================
    // sequencing
    // ==============================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ir         <= '0;
            cycle      <= 1'b0;
            supercycle <= 1'b0;
        end else if (mem_rdy_i) begin
            cycle <= ~cycle;
            if (ctrl_o.ir_we) begin
                ir <= mem_rdata_i;
            end
            // LDI goes round once more after execute
            if (cycle) begin
                supercycle <= op_ldi & ~supercycle;
            end
        end
    end

    // ==============================
    // decode
    // ==============================
    assign is_alu = ~ir.alu_view.is_other;
    assign op_ld  = ir.oth_view.is_other & (ir.oth_view.kind == KIND_LD);
    assign op_st  = ir.oth_view.is_other & (ir.oth_view.kind == KIND_ST);
    assign op_ldi = ir.oth_view.is_other & (ir.oth_view.kind == KIND_LDI);
    assign op_jmp = ir.oth_view.is_other & (ir.oth_view.kind == KIND_JMP);

    // four-way flag select then invert
    assign flag_vec = flags_i;
    assign flag_sel = flag_vec[ir.oth_view.rem.idx];
    assign taken    = ir.oth_view.rem.mode ? ~ir.oth_view.rem.inv
                                           : (flag_sel ^ ir.oth_view.rem.inv);
    assign do_swap  = cycle & op_jmp & taken;

    always_comb begin
        ctrl_o = '0;

        // ALU fields straight from IR
        ctrl_o.alu_op   = ir.alu_view.op;
        ctrl_o.opb_sel  = ir.alu_view.idx;
        ctrl_o.alu_swap = ir.alu_view.dir;
        ctrl_o.st_sel   = ir.oth_view.rem.idx[0];
        ctrl_o.src_mem  = ~is_alu;        // LD and LDI load from memory

        ctrl_o.ir_we   = ~cycle & ~supercycle;   // plain fetch only
        ctrl_o.mem_rd  = ~cycle | op_ld;
        ctrl_o.mem_we  = cycle & op_st;
        ctrl_o.addr_dp = cycle & (op_ld | op_st);
        ctrl_o.swap_p  = do_swap;
        ctrl_o.inc_ip  = cycle & ~do_swap;       // every execute unless jumping

        if (cycle && is_alu) begin
            ctrl_o.reg_we   = 1'b1;
            ctrl_o.reg_sel  = ir.alu_view.dir ? ir.alu_view.idx : REG_A;
            ctrl_o.flags_we = (ir.alu_view.op != ALU_MOV);
        end else if ((cycle && op_ld) || (!cycle && supercycle && op_ldi)) begin
            ctrl_o.reg_we  = 1'b1;
            ctrl_o.reg_sel = ir.oth_view.rem.idx;
        end
    end

    // ==============================
    // checks
    // ==============================
    a_rd_we_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ctrl_o.mem_rd && ctrl_o.mem_we));

    // second pass belongs to LDI and IR must not move under it
    a_super_ldi : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        supercycle |-> op_ldi && $stable(ir));

    a_swap_inc_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ctrl_o.swap_p && ctrl_o.inc_ip));

endmodule

//--- verilog/cpu_pkg.sv
package cpu_pkg;

    // ==============================
    // instruction encoding
    // ==============================
    // ALU : 0 oooo d rr   d=0 A=op(A,r), d=1 r=op(r,A)
    // LD  : 1 00 xxx rr   [DP] -> r
    // ST  : 1 01 xxxx s   s -> [DP]
    // LDI : 1 10 xxx rr   [IP+1] -> r
    // Jc  : 1 11 x0 i ff  jump if flag[ff] ^ i
    // JMP : 1 11 x10 xx
    // NOP : 1 11 x11 xx

    localparam logic [1:0] KIND_LD  = 2'b00;
    localparam logic [1:0] KIND_ST  = 2'b01;
    localparam logic [1:0] KIND_LDI = 2'b10;
    localparam logic [1:0] KIND_JMP = 2'b11;

    localparam logic [1:0] REG_A  = 2'd0;
    localparam logic [1:0] REG_B  = 2'd1;
    localparam logic [1:0] REG_PL = 2'd2; // DP low byte
    localparam logic [1:0] REG_PH = 2'd3; // DP high byte

    localparam logic [3:0] ALU_ADD = 4'b0000;
    localparam logic [3:0] ALU_ADC = 4'b0001;
    localparam logic [3:0] ALU_SUB = 4'b0010;
    localparam logic [3:0] ALU_SBC = 4'b0011;
    localparam logic [3:0] ALU_AND = 4'b0100;
    localparam logic [3:0] ALU_OR  = 4'b0101;
    localparam logic [3:0] ALU_XOR = 4'b0110;
    localparam logic [3:0] ALU_NOT = 4'b0111;
    localparam logic [3:0] ALU_MOV = 4'b1000; // only op that leaves flags alone
    localparam logic [3:0] ALU_SHL = 4'b1001;
    localparam logic [3:0] ALU_SHR = 4'b1010;
    localparam logic [3:0] ALU_ROL = 4'b1011;
    localparam logic [3:0] ALU_ROR = 4'b1100;
    localparam logic [3:0] ALU_INC = 4'b1101;
    localparam logic [3:0] ALU_DEC = 4'b1110;
    localparam logic [3:0] ALU_CLR = 4'b1111;

    localparam logic [15:0] RESET_VECTOR = 16'h0000;

    // ==============================
    // types
    // ==============================
    typedef struct packed {
        logic       is_other; // 0 here
        logic [3:0] op;
        logic       dir;      // 1: result goes to r
        logic [1:0] idx;      // register index
    } alu_form_t;

    // low five bits of a non-ALU instruction
    typedef struct packed {
        logic       rsvd;
        logic       mode;     // 1: JMP/NOP
        logic       inv;      // invert condition
        logic [1:0] idx;      // flag index, or register for LD/LDI/ST
    } oth_rem_t;

    typedef struct packed {
        logic       is_other; // 1 here
        logic [1:0] kind;
        oth_rem_t   rem;
    } oth_form_t;

    typedef union packed {
        alu_form_t alu_view;
        oth_form_t oth_view;
    } instr_u;

    // bit 0 is z, up to v at bit 3
    typedef struct packed {
        logic v;
        logic n;
        logic c;
        logic z;
    } flags_t;

    typedef struct packed {
        logic       ir_we;    // latch IR
        logic       inc_ip;
        logic       swap_p;   // exchange IP and DP
        logic       addr_dp;  // address from DP instead of IP
        logic       mem_rd;
        logic       mem_we;
        logic       reg_we;
        logic [1:0] reg_sel;  // A, B, PL, PH
        logic       src_mem;  // write-back from memory, else ALU
        logic       flags_we;
        logic [3:0] alu_op;
        logic [1:0] opb_sel;  // ALU operand register
        logic       alu_swap; // d = op(d, A) form
        logic       st_sel;   // store A (0) or B (1)
    } ctrl_t;

    typedef struct packed {
        logic [15:0] addr;
        logic        rd;
        logic        we;
        logic [7:0]  wdata;
    } mem_req_t;

endpackage

//--- verilog/cpu_top.sv
module cpu_top (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic [7:0]        mem_rdata_i,
    input  logic              mem_rdy_i,
    output cpu_pkg::mem_req_t mem_req_o
);
    import cpu_pkg::*;

    ctrl_t       ctrl;
    flags_t      flags;      // stored flags
    flags_t      alu_flags;  // flags from current ALU op
    logic [7:0]  reg_a;
    logic [7:0]  reg_b;
    logic [7:0]  pl;
    logic [7:0]  ph;
    logic [15:0] addr;
    logic [7:0]  opd;        // register picked by opb_sel
    logic [7:0]  alu_x;
    logic [7:0]  alu_y;
    logic [7:0]  alu_res;
    logic [7:0]  wb_data;
    logic [7:0]  st_data;

    control_unit u_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mem_rdy_i   (mem_rdy_i),
        .mem_rdata_i (mem_rdata_i),
        .flags_i     (flags),
        .ctrl_o      (ctrl)
    );

    // ==============================
    // datapath muxes
    // ==============================
    always_comb begin
        unique case (ctrl.opb_sel)
            REG_A:  opd = reg_a;
            REG_B:  opd = reg_b;
            REG_PL: opd = pl;
            REG_PH: opd = ph;
        endcase
    end

    assign alu_x   = ctrl.alu_swap ? opd : reg_a;    // d = op(d, A)
    assign alu_y   = ctrl.alu_swap ? reg_a : opd;
    assign wb_data = ctrl.src_mem ? mem_rdata_i : alu_res;
    assign st_data = ctrl.st_sel ? reg_b : reg_a;

    alu u_alu (
        .op_i    (ctrl.alu_op),
        .a_i     (alu_x),
        .b_i     (alu_y),
        .carry_i (flags.c),
        .res_o   (alu_res),
        .flags_o (alu_flags)
    );

    reg_file u_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ctrl_i      (ctrl),
        .mem_rdy_i   (mem_rdy_i),
        .wdata_i     (wb_data),
        .alu_flags_i (alu_flags),
        .a_o         (reg_a),
        .b_o         (reg_b),
        .flags_o     (flags)
    );

    pointer_unit u_ptrs (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .ctrl_i    (ctrl),
        .mem_rdy_i (mem_rdy_i),
        .wdata_i   (wb_data),
        .addr_o    (addr),
        .pl_o      (pl),
        .ph_o      (ph)
    );

    // request is pure decode of state, so it holds through a stall
    assign mem_req_o = '{addr: addr, rd: ctrl.mem_rd, we: ctrl.mem_we, wdata: st_data};

endmodule

//--- verilog/pointer_unit.sv
module pointer_unit (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  cpu_pkg::ctrl_t ctrl_i,
    input  logic           mem_rdy_i,
    input  logic [7:0]     wdata_i,   // write-back byte for PL/PH
    output logic [15:0]    addr_o,
    output logic [7:0]     pl_o,
    output logic [7:0]     ph_o
);
    import cpu_pkg::*;

    logic [15:0] ptr [2];  // IP and DP with roles set by sel
    logic        sel;      // which ptr is IP
    logic        dp_idx;
    logic [15:0] ip;
    logic [15:0] dp;
    logic        we_pl;
    logic        we_ph;

    assign dp_idx = ~sel;
    assign ip     = ptr[sel];
    assign dp     = ptr[dp_idx];

    assign we_pl = ctrl_i.reg_we & (ctrl_i.reg_sel == REG_PL);
    assign we_ph = ctrl_i.reg_we & (ctrl_i.reg_sel == REG_PH);

    // ==============================
    // pointer update
    // ==============================
    // on swap old IP+1 becomes DP (return address) and old DP becomes IP
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptr[0] <= RESET_VECTOR;
            ptr[1] <= RESET_VECTOR;
            sel    <= 1'b0;         // ptr 0 starts as IP
        end else if (mem_rdy_i) begin
            if (ctrl_i.inc_ip || ctrl_i.swap_p) begin
                ptr[sel] <= ip + 16'd1;
            end
            if (ctrl_i.swap_p) begin
                sel <= ~sel;
            end
            if (we_pl) begin
                ptr[dp_idx][7:0] <= wdata_i;
            end
            if (we_ph) begin
                ptr[dp_idx][15:8] <= wdata_i;
            end
        end
    end

    assign addr_o = ctrl_i.addr_dp ? dp : ip;
    assign pl_o   = dp[7:0];
    assign ph_o   = dp[15:8];

endmodule

//--- verilog/reg_file.sv
module reg_file (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  cpu_pkg::ctrl_t  ctrl_i,
    input  logic            mem_rdy_i,
    input  logic [7:0]      wdata_i,     // write-back byte
    input  cpu_pkg::flags_t alu_flags_i,
    output logic [7:0]      a_o,
    output logic [7:0]      b_o,
    output cpu_pkg::flags_t flags_o
);
    import cpu_pkg::*;

    logic we_a;
    logic we_b;

    // PL/PH writes land in the pointer unit
    assign we_a = ctrl_i.reg_we & (ctrl_i.reg_sel == REG_A);
    assign we_b = ctrl_i.reg_we & (ctrl_i.reg_sel == REG_B);

    // ==============================
    // accumulators and flags
    // ==============================
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            a_o     <= '0;
            b_o     <= '0;
            flags_o <= '0;
        end else if (mem_rdy_i) begin   // stall freezes all
            if (we_a) begin
                a_o <= wdata_i;
            end
            if (we_b) begin
                b_o <= wdata_i;
            end
            if (ctrl_i.flags_we) begin
                flags_o <= alu_flags_i;
            end
        end
    end

    // ALU execute and store execute are different instructions
    a_flags_no_store : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ctrl_i.flags_we && ctrl_i.mem_we));

endmodule
